/* common/gray_pkg.sv */
package gray_pkg;

    // Pixel and user-port widths
    localparam int RGB_W      = 24;
    localparam int GRAY_W     = 8;
    localparam int DDR_ADDR_W = 32;
    localparam int DDR_DATA_W = 128;

    // Red in 23:16, green in 15:8, blue in 7:0
    typedef logic [RGB_W-1:0]      rgb_pixel_t;
    typedef logic [GRAY_W-1:0]     gray_t;
    typedef logic [DDR_ADDR_W-1:0] ddr_addr_t;
    typedef logic [DDR_DATA_W-1:0] ddr_data_t;

    // Scratch location reused by every pixel
    localparam ddr_addr_t BASE_ADDRESS = 32'h01000000;

    // Both FIFOs, depth must be a power of two
    localparam int FIFO_DEPTH   = 16;
    localparam int FIFO_PTR_W   = $clog2(FIFO_DEPTH);
    localparam int FIFO_COUNT_W = $clog2(FIFO_DEPTH + 1);

    // Scratch RAM holds one entry per 16-byte user-port word
    localparam int RAM_WORDS     = 16;
    localparam int RAM_INDEX_W   = $clog2(RAM_WORDS);
    localparam int WORD_OFFSET_W = $clog2(DDR_DATA_W / 8);

    // Access latencies in cycles, counter sized for the longer one
    localparam int WRITE_LATENCY = 4;
    localparam int READ_LATENCY  = 6;
    localparam int LAT_COUNT_W   = $clog2(READ_LATENCY + 1);

endpackage

/* dv/gray_pipeline_tb.sv */
module gray_pipeline_tb;

    localparam int PIXEL_COUNT  = 600;
    localparam int STALL_CYCLES = 400;
    localparam int IDLE_CYCLES  = 60;
    // Both FIFOs full plus the one pixel held by the grayscale block
    localparam int MAX_HELD     = 2 * gray_pkg::FIFO_DEPTH + 1;
    // Room for a full pipeline of pixels at up to 16 cycles each
    localparam int DRAIN_CYCLES = MAX_HELD * 16;
    // 600 pixels at up to 16 cycles each plus the stall, drain and idle tail
    localparam int TIMEOUT_CYCLES = 12000;

    logic                 clock;
    logic                 reset;
    logic                 in_wr_en;
    gray_pkg::rgb_pixel_t in_din;
    logic                 in_full;
    logic                 out_rd_en;
    gray_pkg::gray_t      out_dout;
    logic                 out_empty;

    // Expected gray values in arrival order
    gray_pkg::gray_t      expected_q[$];
    gray_pkg::rgb_pixel_t forced_q[$];
    int                   sent_count = 0;
    int                   cycle_count = 0;
    int                   drain_count = 0;

    gray_pipeline_top UUT (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    always #20 clock = ~clock;

    // Floor of the channel average
    function automatic gray_pkg::gray_t expected_gray(input gray_pkg::rgb_pixel_t pixel);
        int sum;
        sum = int'(pixel[23:16]) + int'(pixel[15:8]) + int'(pixel[7:0]);
        return gray_pkg::gray_t'(sum / 3);
    endfunction

    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_gray(input gray_pkg::gray_t actual, input gray_pkg::gray_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is %02h, expected %02h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input bit actual, input bit expected, input string what);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s is %0b, expected %0b",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // One clock cycle of source and sink activity driven just after the edge
    task automatic run_cycle(input bit allow_write, input int pop_percent);
        gray_pkg::rgb_pixel_t pixel;
        gray_pkg::gray_t      expected;
        @(posedge clock);
        #2;

        // Sink pops the head while dout holds until the next edge
        out_rd_en = 1'b0;
        if (!out_empty && ($urandom_range(99) < pop_percent)) begin
            if (expected_q.size() == 0) begin
                $display("The DUT produced gray value %02h with no pixel pending at time %0t",
                         out_dout, $time);
                stop_with_failure();
            end
            expected = expected_q.pop_front();
            check_gray(out_dout, expected, "out_dout");
            out_rd_en = 1'b1;
        end

        // Forced pixels go out before random ones
        in_wr_en = 1'b0;
        if (allow_write && !in_full && (sent_count < PIXEL_COUNT)) begin
            if (forced_q.size() > 0) begin
                pixel = forced_q.pop_front();
                in_wr_en = 1'b1;
            end else if ($urandom_range(1) == 1) begin
                pixel = gray_pkg::rgb_pixel_t'($urandom);
                in_wr_en = 1'b1;
            end
            if (in_wr_en) begin
                in_din = pixel;
                expected_q.push_back(expected_gray(pixel));
                sent_count++;
            end
        end
    endtask

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d of %0d pixels sent and %0d not yet read",
                     cycle_count, sent_count, PIXEL_COUNT, expected_q.size());
            stop_with_failure();
        end
    end

    initial begin
        clock     = 1'b0;
        reset     = 1'b1;
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        void'($urandom(32'h8662));

        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;
        check_flag(out_empty, 1'b1, "out_empty after reset");
        check_flag(in_full, 1'b0, "in_full after reset");

        // Corner pixels black, white and pure red
        forced_q.push_back(24'h000000);
        forced_q.push_back(24'hFFFFFF);
        forced_q.push_back(24'hFF0000);

        // Moderate sink followed by a fast one
        while (sent_count < 200) begin
            run_cycle(1'b1, 50);
        end
        while (sent_count < 350) begin
            run_cycle(1'b1, 90);
        end

        // Sink stalls while the source keeps offering pixels
        repeat (STALL_CYCLES) begin
            run_cycle(1'b1, 0);
        end
        check_flag(in_full, 1'b1, "in_full at end of output stall");
        check_flag(expected_q.size() <= MAX_HELD, 1'b1, "pixels held within FIFO capacity");

        // Slow sink for the rest of the pixels
        while (sent_count < PIXEL_COUNT) begin
            run_cycle(1'b1, 25);
        end

        while ((expected_q.size() > 0) && (drain_count < DRAIN_CYCLES)) begin
            run_cycle(1'b0, 75);
            drain_count++;
        end

        // Nothing may come out once everything has drained
        repeat (IDLE_CYCLES) begin
            run_cycle(1'b0, 100);
            check_flag(out_empty, 1'b1, "out_empty while idle");
        end

        if (expected_q.size() != 0) begin
            $display("%0d expected gray values were never read", expected_q.size());
            $display("Done: errors found");
            $fatal(1, "simulation stopped with pending pixels");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

/* grayscale/grayscale.sv */
module grayscale (
    input  logic                 clock,
    input  logic                 reset,

    // Input pixel FIFO
    output logic                 in_rd_en,
    input  logic                 in_empty,
    input  gray_pkg::rgb_pixel_t in_dout,

    // DDR3 user port
    output gray_pkg::ddr_addr_t  sdram_address,
    output logic                 rd_en,
    output logic                 wr_en,
    output gray_pkg::ddr_data_t  write_data_input,
    input  gray_pkg::ddr_data_t  read_data,
    input  logic                 write_complete,
    input  logic                 read_complete,

    // Output gray FIFO
    output logic                 out_wr_en,
    input  logic                 out_full,
    output gray_pkg::gray_t      out_din
);

    typedef enum logic [2:0] {
        IDLE,
        MEM_WRITE,
        WRITE_WAIT,
        MEM_READ,
        READ_WAIT,
        OUTPUT
    } state_t;

    state_t          state;
    state_t          next_state;
    logic [9:0]      channel_sum;
    gray_pkg::gray_t gray_q;
    gray_pkg::gray_t gray_c;
    gray_pkg::gray_t readback_q;
    gray_pkg::gray_t readback_c;

    // Sum of three bytes peaks at 765, so ten bits hold it
    assign channel_sum = {2'b00, in_dout[23:16]}
                       + {2'b00, in_dout[15:8]}
                       + {2'b00, in_dout[7:0]};

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        gray_q     <= gray_c;
        readback_q <= readback_c;
    end

    // The emitted value is the byte that came back from memory
    assign out_din = readback_q;

    always_comb begin
        next_state       = state;
        gray_c           = gray_q;
        readback_c       = readback_q;
        in_rd_en         = 1'b0;
        out_wr_en        = 1'b0;
        sdram_address    = '0;
        rd_en            = 1'b0;
        wr_en            = 1'b0;
        write_data_input = '0;

        case (state)
            IDLE: begin
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    gray_c     = gray_pkg::gray_t'(channel_sum / 10'd3);
                    next_state = MEM_WRITE;
                end
            end
            MEM_WRITE: begin
                sdram_address                           = gray_pkg::BASE_ADDRESS;
                write_data_input[gray_pkg::GRAY_W-1:0]  = gray_q;
                wr_en                                   = 1'b1;
                next_state                              = WRITE_WAIT;
            end
            WRITE_WAIT: begin
                if (write_complete) begin
                    next_state = MEM_READ;
                end
            end
            MEM_READ: begin
                sdram_address = gray_pkg::BASE_ADDRESS;
                rd_en         = 1'b1;
                next_state    = READ_WAIT;
            end
            READ_WAIT: begin
                if (read_complete) begin
                    readback_c = read_data[gray_pkg::GRAY_W-1:0];
                    next_state = OUTPUT;
                end
            end
            OUTPUT: begin
                // Stall here while the output FIFO is full
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

endmodule

/* rtl/ddr3_scratch_ram.sv */
module ddr3_scratch_ram (
    input  logic                clock,
    input  logic                reset,
    input  gray_pkg::ddr_addr_t sdram_address,
    input  logic                rd_en,
    input  logic                wr_en,
    input  gray_pkg::ddr_data_t write_data_input,
    output gray_pkg::ddr_data_t read_data,
    output logic                write_complete,
    output logic                read_complete
);

    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE,
        OP_READ
    } op_t;

    gray_pkg::ddr_data_t mem [gray_pkg::RAM_WORDS];

    gray_pkg::ddr_addr_t                addr_offset;
    logic [gray_pkg::RAM_INDEX_W-1:0]   word_index;
    logic [gray_pkg::LAT_COUNT_W-1:0]   count;
    op_t                                pending;
    gray_pkg::ddr_data_t                read_word;
    logic                               accept_write;
    logic                               accept_read;
    logic                               finishing;

    // Word index from the byte offset, addresses outside the window wrap
    assign addr_offset = sdram_address - gray_pkg::BASE_ADDRESS;
    assign word_index  = addr_offset[gray_pkg::WORD_OFFSET_W +: gray_pkg::RAM_INDEX_W];

    // One access at a time, a write wins over a simultaneous read
    assign accept_write = wr_en && (pending == OP_NONE);
    assign accept_read  = rd_en && !wr_en && (pending == OP_NONE);

    // Last counted cycle of the pending access
    assign finishing = (pending != OP_NONE) && (count == gray_pkg::LAT_COUNT_W'(1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending        <= OP_NONE;
            count          <= '0;
            write_complete <= 1'b0;
            read_complete  <= 1'b0;
        end else begin
            write_complete <= 1'b0;
            read_complete  <= 1'b0;

            if (accept_write) begin
                pending <= OP_WRITE;
                count   <= gray_pkg::LAT_COUNT_W'(gray_pkg::WRITE_LATENCY - 1);
            end else if (accept_read) begin
                pending <= OP_READ;
                count   <= gray_pkg::LAT_COUNT_W'(gray_pkg::READ_LATENCY - 1);
            end else if (finishing) begin
                // Completion pulse lands exactly one latency after the request
                pending        <= OP_NONE;
                write_complete <= (pending == OP_WRITE);
                read_complete  <= (pending == OP_READ);
            end else if (pending != OP_NONE) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept_write) begin
            mem[word_index] <= write_data_input;
        end
        if (accept_read) begin
            read_word <= mem[word_index];
        end
        if (finishing && (pending == OP_READ)) begin
            read_data <= read_word;
        end
    end

endmodule

/* rtl/gray_pipeline_top.sv */
module gray_pipeline_top (
    input  logic                 clock,
    input  logic                 reset,

    // Pixel source side
    input  logic                 in_wr_en,
    input  gray_pkg::rgb_pixel_t in_din,
    output logic                 in_full,

    // Gray sink side
    input  logic                 out_rd_en,
    output gray_pkg::gray_t      out_dout,
    output logic                 out_empty
);

    logic                 fifo_rd_en;
    logic                 fifo_empty;
    gray_pkg::rgb_pixel_t fifo_dout;

    gray_pkg::ddr_addr_t  mem_address;
    logic                 mem_rd_en;
    logic                 mem_wr_en;
    gray_pkg::ddr_data_t  mem_write_data;
    gray_pkg::ddr_data_t  mem_read_data;
    logic                 mem_write_complete;
    logic                 mem_read_complete;

    logic                 gray_wr_en;
    logic                 gray_full;
    gray_pkg::gray_t      gray_din;

    sync_fifo #(
        .payload_t (gray_pkg::rgb_pixel_t)
    ) input_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (fifo_rd_en),
        .dout  (fifo_dout),
        .empty (fifo_empty)
    );

    grayscale grayscale_inst (
        .clock            (clock),
        .reset            (reset),
        .in_rd_en         (fifo_rd_en),
        .in_empty         (fifo_empty),
        .in_dout          (fifo_dout),
        .sdram_address    (mem_address),
        .rd_en            (mem_rd_en),
        .wr_en            (mem_wr_en),
        .write_data_input (mem_write_data),
        .read_data        (mem_read_data),
        .write_complete   (mem_write_complete),
        .read_complete    (mem_read_complete),
        .out_wr_en        (gray_wr_en),
        .out_full         (gray_full),
        .out_din          (gray_din)
    );

    // Stands in for the external DDR3 behind the same user port
    ddr3_scratch_ram scratch_ram (
        .clock            (clock),
        .reset            (reset),
        .sdram_address    (mem_address),
        .rd_en            (mem_rd_en),
        .wr_en            (mem_wr_en),
        .write_data_input (mem_write_data),
        .read_data        (mem_read_data),
        .write_complete   (mem_write_complete),
        .read_complete    (mem_read_complete)
    );

    sync_fifo #(
        .payload_t (gray_pkg::gray_t)
    ) output_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (gray_wr_en),
        .din   (gray_din),
        .full  (gray_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

/* rtl/sync_fifo.sv */
module sync_fifo #(
    parameter type payload_t = gray_pkg::gray_t
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    payload_t mem [gray_pkg::FIFO_DEPTH];

    logic [gray_pkg::FIFO_PTR_W-1:0]   wr_ptr;
    logic [gray_pkg::FIFO_PTR_W-1:0]   rd_ptr;
    logic [gray_pkg::FIFO_COUNT_W-1:0] count;
    logic                              do_write;
    logic                              do_read;

    // Writes into a full FIFO and pops from an empty one are dropped
    assign do_write = wr_en && !full;
    assign do_read  = rd_en && !empty;

    assign empty = (count == '0);
    assign full  = (count == gray_pkg::FIFO_COUNT_W'(gray_pkg::FIFO_DEPTH));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap naturally at the power-of-two depth
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({do_write, do_read})
                2'b10: begin
                    count <= count + 1'b1;
                end
                2'b01: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    // Show-ahead: the head entry is visible while empty is low
    assign dout = mem[rd_ptr];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the grayscale pipeline testbench with Verilator
set -o pipefail

cd "$(dirname "$0")" || exit 1

verilator --binary -f tb.f --top-module gray_pipeline_tb \
    && ./obj_dir/Vgray_pipeline_tb | tee sim.log \
    && ! grep -q "Done: errors found" sim.log \
    || exit 1

exit 0

/* tb.f */
common/gray_pkg.sv
rtl/sync_fifo.sv
grayscale/grayscale.sv
rtl/ddr3_scratch_ram.sv
rtl/gray_pipeline_top.sv
dv/gray_pipeline_tb.sv
